// ==== verilog/opUnitPkg.sv ====
package opUnitPkg;

	// ----------------------------------------
	// sizes
	// ----------------------------------------
	localparam int NumClients = 3;       // request clients
	localparam int ClientIdxWidth = 2;   // fits NumClients
	localparam int DataWidth = 32;
	localparam int RegCount = 16;
	localparam int RegAddrWidth = 4;
	localparam int FifoDepth = 4;        // per client, power of two

	// registers sit at apb words 0..RegCount-1
	localparam int StatusAddr = 16;      // completion count
	localparam int ApbAddrWidth = 5;

	// ----------------------------------------
	// types
	// ----------------------------------------
	typedef enum logic [1:0]
	{
		OpAdd = 2'd0,
		OpOr  = 2'd1,
		OpAnd = 2'd2
		// 2'd3 unused
	} opCodeT;

	// one state per executor cycle
	typedef enum logic [1:0]
	{
		ExecIdle  = 2'd0,   // waiting for a grant
		ExecReadA = 2'd1,   // srcA on the port
		ExecReadB = 2'd2,   // srcB on the port, A returning
		ExecWrite = 2'd3    // B returning, result written
	} execStateT;

	// 14 bit request word
	typedef struct packed
	{
		opCodeT opCode;
		logic [RegAddrWidth-1:0] srcA;
		logic [RegAddrWidth-1:0] srcB;
		logic [RegAddrWidth-1:0] dest;
	} opRequestT;

endpackage

// ==== verilog/regPortIf.sv ====
`timescale 1ns/1ps

// one synchronous register file port
// readData follows the addr of the previous cycle
interface regPortIf
	import opUnitPkg::*;
	();

	logic [RegAddrWidth-1:0] addr;
	logic [DataWidth-1:0] writeData;
	logic writeEnable;          // write on the rising edge
	logic [DataWidth-1:0] readData;   // old content, or writeData on a write

	// the port owner side
	modport user
	(
		output addr,
		output writeData,
		output writeEnable,
		input readData
	);

	// the storage side
	modport file
	(
		input addr,
		input writeData,
		input writeEnable,
		output readData
	);

endinterface

// ==== verilog/requestFifo.sv ====
`timescale 1ns/1ps

module requestFifo
	import opUnitPkg::*;
#(
	parameter int Depth = FifoDepth   // power of two, at least 2
)
(
	input logic Clock,
	input logic Reset,
	input logic push,
	input opRequestT pushData,
	input logic pop,
	output opRequestT head,
	output logic full,
	output logic empty
);

	localparam int AddrWidth = $clog2(Depth);

	opRequestT mem [Depth];
	logic [AddrWidth:0] writePtr;   // msb is the wrap bit
	logic [AddrWidth:0] readPtr;    // msb is the wrap bit
	logic doPush;
	logic doPop;

	assign doPush = push & ~full;   // push while full dropped
	assign doPop = pop & ~empty;    // pop while empty dropped

	// ----------------------------------------
	// flags
	// ----------------------------------------
	// equal pointers, nothing stored
	assign empty = (writePtr == readPtr);
	// same slot, one lap apart
	assign full = (writePtr[AddrWidth] != readPtr[AddrWidth])
		&& (writePtr[AddrWidth-1:0] == readPtr[AddrWidth-1:0]);

	// head shows without a read cycle
	assign head = mem[readPtr[AddrWidth-1:0]];

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			writePtr <= '0;
			readPtr <= '0;
		end
		else
		begin
			if (doPush)
				writePtr <= writePtr + 1'b1;
			if (doPop)
				readPtr <= readPtr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge Clock)
	begin
		if (doPush)
			mem[writePtr[AddrWidth-1:0]] <= pushData;
	end

endmodule

// ==== verilog/roundRobinArbiter.sv ====
`timescale 1ns/1ps

module roundRobinArbiter
	import opUnitPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic [NumClients-1:0] empty,
	input opRequestT [NumClients-1:0] heads,
	input logic execReady,
	output logic [NumClients-1:0] pop,
	output logic grantValid,
	output opRequestT grantOp
);

	logic [ClientIdxWidth-1:0] priorityPtr;   // first client with priority
	logic [NumClients-1:0] requestVec;
	logic [NumClients-1:0] priorityMask;
	logic [NumClients-1:0] maskedRequest;
	logic [NumClients-1:0] grantOneHot;
	logic [ClientIdxWidth-1:0] winner;
	logic maskedFound;

	assign requestVec = ~empty;
	assign maskedRequest = requestVec & priorityMask;

	// clients at or above the pointer
	always_comb
	begin
		for (int i = 0; i < NumClients; i++)
			priorityMask[i] = (i >= priorityPtr);
	end

	// ----------------------------------------
	// winner select
	// ----------------------------------------
	always_comb
	begin
		// lowest masked request first, loop runs downward
		winner = '0;
		maskedFound = 1'b0;
		for (int i = NumClients - 1; i >= 0; i--)
		begin
			if (maskedRequest[i])
			begin
				winner = ClientIdxWidth'(i);
				maskedFound = 1'b1;
			end
		end

		// nothing above the pointer, wrap to the lowest one
		if (!maskedFound)
		begin
			for (int i = NumClients - 1; i >= 0; i--)
			begin
				if (requestVec[i])
					winner = ClientIdxWidth'(i);
			end
		end
	end

	assign grantValid = execReady & (|requestVec);
	assign grantOneHot = NumClients'(1) << winner;
	assign pop = grantValid ? grantOneHot : '0;   // one fifo popped per grant
	assign grantOp = heads[winner];

	// pointer moves past the winner
	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
			priorityPtr <= '0;   // client 0 first
		else if (grantValid)
		begin
			if (winner == ClientIdxWidth'(NumClients - 1))
				priorityPtr <= '0;
			else
				priorityPtr <= winner + 1'b1;
		end
	end

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps

// RegCount x DataWidth, two independent synchronous ports
module registerFile
	import opUnitPkg::*;
(
	input logic Clock,
	regPortIf.file portA,   // apb side
	regPortIf.file portB    // executor side
);

	logic [DataWidth-1:0] ram [RegCount];

	// ----------------------------------------
	// ports
	// ----------------------------------------
	// same port write reads the new data,
	// the other port sees the old word this cycle
	always_ff @(posedge Clock)
	begin
		// port A
		if (portA.writeEnable)
		begin
			ram[portA.addr] <= portA.writeData;
			portA.readData <= portA.writeData;   // write-through
		end
		else
			portA.readData <= ram[portA.addr];

		// port B wins a same-address collision
		if (portB.writeEnable)
		begin
			ram[portB.addr] <= portB.writeData;
			portB.readData <= portB.writeData;   // write-through
		end
		else
			portB.readData <= ram[portB.addr];
	end

endmodule

// ==== verilog/opExecutor.sv ====
`timescale 1ns/1ps

module opExecutor
	import opUnitPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic grantValid,
	input opRequestT grantOp,
	output logic execReady,
	output logic execWriting,
	output logic [DataWidth-1:0] opCount,
	regPortIf.user regPort
);

	execStateT state;
	execStateT nextState;
	opRequestT currentOp;              // captured in idle
	logic [DataWidth-1:0] operandA;    // held until B arrives
	logic [DataWidth-1:0] aluResult;

	assign execReady = (state == ExecIdle);
	assign execWriting = (state == ExecWrite);

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_comb
	begin
		case (state)
			ExecIdle: nextState = grantValid ? ExecReadA : ExecIdle;
			ExecReadA: nextState = ExecReadB;
			ExecReadB: nextState = ExecWrite;
			default: nextState = ExecIdle;   // write done, ready next cycle
		endcase
	end

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			state <= ExecIdle;
			opCount <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == ExecWrite)
				opCount <= opCount + 1'b1;   // one per write-back
		end
	end

	// request and first operand
	always_ff @(posedge Clock)
	begin
		if (state == ExecIdle && grantValid)
			currentOp <= grantOp;
		if (state == ExecReadB)
			operandA <= regPort.readData;   // srcA from last cycle
	end

	// ----------------------------------------
	// alu with B taken straight off the port
	// ----------------------------------------
	always_comb
	begin
		case (currentOp.opCode)
			OpAdd: aluResult = operandA + regPort.readData;
			OpOr: aluResult = operandA | regPort.readData;
			OpAnd: aluResult = operandA & regPort.readData;
			default: aluResult = '0;   // spare code
		endcase
	end

	// port B address per state
	always_comb
	begin
		case (state)
			ExecReadB: regPort.addr = currentOp.srcB;
			ExecWrite: regPort.addr = currentOp.dest;
			default: regPort.addr = currentOp.srcA;   // idle value unused
		endcase
		regPort.writeData = aluResult;
		regPort.writeEnable = (state == ExecWrite);
	end

endmodule

// ==== verilog/apbRegAccess.sv ====
`timescale 1ns/1ps

module apbRegAccess
	import opUnitPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input logic [ApbAddrWidth-1:0] PADDR,
	input logic [DataWidth-1:0] PWDATA,
	output logic [DataWidth-1:0] PRDATA,
	output logic PREADY,
	input logic execWriting,
	input logic [DataWidth-1:0] opCount,
	regPortIf.user regPort
);

	logic writingLast;    // executor wrote last cycle
	logic accessPhase;
	logic regSelect;      // address inside the register file
	logic statusSelect;   // completion counter

	assign accessPhase = PSEL & PENABLE;
	assign regSelect = (PADDR < ApbAddrWidth'(RegCount));
	assign statusSelect = (PADDR == ApbAddrWidth'(StatusAddr));

	// ----------------------------------------
	// wait states
	// ----------------------------------------
	// port A readData is stale right after a port B write,
	// and a write now could hit the same word
	assign PREADY = ~(accessPhase & (execWriting | writingLast));

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
			writingLast <= 1'b0;
		else
			writingLast <= execWriting;
	end

	// address from PADDR every cycle, read returns in access
	assign regPort.addr = PADDR[RegAddrWidth-1:0];
	assign regPort.writeData = PWDATA;
	assign regPort.writeEnable = accessPhase & PWRITE & PREADY & regSelect;

	always_comb
	begin
		if (regSelect)
			PRDATA = regPort.readData;
		else if (statusSelect)
			PRDATA = opCount;
		else
			PRDATA = '0;   // above the counter
	end

endmodule

// ==== verilog/opUnitTop.sv ====
`timescale 1ns/1ps

module opUnitTop
	import opUnitPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic [NumClients-1:0] push,
	input opRequestT [NumClients-1:0] request,
	output logic [NumClients-1:0] full,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input logic [ApbAddrWidth-1:0] PADDR,
	input logic [DataWidth-1:0] PWDATA,
	output logic [DataWidth-1:0] PRDATA,
	output logic PREADY
);

	opRequestT [NumClients-1:0] heads;
	logic [NumClients-1:0] empty;
	logic [NumClients-1:0] pop;       // one-hot from the arbiter
	logic grantValid;
	opRequestT grantOp;
	logic execReady;
	logic execWriting;
	logic [DataWidth-1:0] opCount;

	regPortIf apbPort ();    // port A
	regPortIf execPort ();   // port B

	// ----------------------------------------
	// client request queues
	// ----------------------------------------
	for (genvar c = 0; c < NumClients; c++)
	begin : clientQueue
		requestFifo #(.Depth(FifoDepth)) fifo
		(
			.Clock(Clock),
			.Reset(Reset),
			.push(push[c]),
			.pushData(request[c]),
			.pop(pop[c]),
			.head(heads[c]),
			.full(full[c]),
			.empty(empty[c])
		);
	end

	roundRobinArbiter arbiter
	(
		.Clock(Clock),
		.Reset(Reset),
		.empty(empty),
		.heads(heads),
		.execReady(execReady),
		.pop(pop),
		.grantValid(grantValid),
		.grantOp(grantOp)
	);

	opExecutor executor
	(
		.Clock(Clock),
		.Reset(Reset),
		.grantValid(grantValid),
		.grantOp(grantOp),
		.execReady(execReady),
		.execWriting(execWriting),
		.opCount(opCount),
		.regPort(execPort.user)
	);

	// host access and storage
	apbRegAccess apbSlave
	(
		.Clock(Clock),
		.Reset(Reset),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.execWriting(execWriting),
		.opCount(opCount),
		.regPort(apbPort.user)
	);

	registerFile regFile
	(
		.Clock(Clock),
		.portA(apbPort.file),
		.portB(execPort.file)
	);

endmodule

// ==== testbench/opUnitTests.svh ====
// ----------------------------------------
// directed tests
// ----------------------------------------

task automatic resetStateTest();
	logic [DataWidth-1:0] value;
	startTest("reset state");
	@(negedge Clock);
	if (full !== '0)
		reportMismatch("full", '0, DataWidth'(full));
	apbRead(ApbAddrWidth'(StatusAddr), value);
	if (value !== '0)
		reportMismatch("completion count", '0, value);
	finishTest();
endtask

// preload every register, read back, then the unmapped range
task automatic registerFileTest();
	logic [DataWidth-1:0] value;
	int waitsBefore;
	startTest("register file");
	waitsBefore = waitCycles;
	for (int r = 0; r < RegCount; r++)
		apbWrite(ApbAddrWidth'(r), randomBits(DataWidth));
	for (int r = 0; r < RegCount; r++)
	begin
		apbRead(ApbAddrWidth'(r), value);
		if (value !== regModel[r])
			reportMismatch($sformatf("r%0d", r), regModel[r], value);
	end
	apbRead(ApbAddrWidth'(StatusAddr + 1), value);   // first word past the counter
	if (value !== '0)
		reportMismatch("address 17", '0, value);
	apbRead('1, value);
	if (value !== '0)
		reportMismatch("address 31", '0, value);
	// executor idle throughout, no transfer may stall
	if (waitCycles != waitsBefore)
		reportMismatch("wait states while idle", '0, DataWidth'(waitCycles - waitsBefore));
	finishTest();
endtask

// all three chain on r12, so the result shows the grant order
task automatic roundRobinTest();
	opRequestT [NumClients-1:0] reqs;
	logic [NumClients-1:0] accepted;
	logic [DataWidth-1:0] value;
	startTest("round robin");
	reqs[0] = makeRequest(OpAdd, 12, 1, 12);
	reqs[1] = makeRequest(OpAnd, 12, 2, 12);
	reqs[2] = makeRequest(OpOr, 12, 3, 12);
	pushClients('1, reqs, accepted);
	if (accepted !== '1)
		reportFailure("a push into an empty queue was refused");
	for (int c = 0; c < NumClients; c++)
		applyToModel(reqs[c]);   // order 0, 1, 2
	expectedCount += 3;
	waitForCount(expectedCount);
	apbRead(ApbAddrWidth'(12), value);
	if (value !== regModel[12])
		reportMismatch("r12 after clients 0,1,2", regModel[12], value);

	// pointer wrapped after client 2
	reqs[0] = makeRequest(OpAdd, 12, 12, 12);   // doubles r12
	reqs[1] = makeRequest(OpOr, 12, 5, 12);
	reqs[2] = '0;
	pushClients(3'b011, reqs, accepted);
	if (accepted !== 3'b011)
		reportFailure("a push into an empty queue was refused");
	applyToModel(reqs[0]);
	applyToModel(reqs[1]);
	expectedCount += 2;
	waitForCount(expectedCount);
	apbRead(ApbAddrWidth'(12), value);
	if (value !== regModel[12])
		reportMismatch("r12 after clients 0,1", regModel[12], value);
	finishTest();
endtask

// one of each opcode from client 0, the last uses the first two results
task automatic opcodeTest();
	opRequestT [NumClients-1:0] reqs;
	opRequestT ops [3];
	logic [NumClients-1:0] accepted;
	logic [DataWidth-1:0] value;
	int waitsBefore;
	startTest("opcodes");
	ops[0] = makeRequest(OpAdd, 1, 2, 8);
	ops[1] = makeRequest(OpOr, 3, 4, 9);
	ops[2] = makeRequest(OpAnd, 8, 9, 10);
	reqs = '0;
	for (int i = 0; i < 3; i++)
	begin
		reqs[0] = ops[i];
		pushClients(3'b001, reqs, accepted);
		if (accepted !== 3'b001)
			reportFailure("client 0 refused a push");
		applyToModel(ops[i]);
		expectedCount++;
		// now in executor cycle 1, the access phase lands on write-back in cycle 3
		@(negedge Clock);
		waitsBefore = waitCycles;
		apbRead(ApbAddrWidth'(StatusAddr), value);
		// low in the write cycle and the one after
		if (waitCycles - waitsBefore != 2)
			reportMismatch("wait states at write-back", 2, DataWidth'(waitCycles - waitsBefore));
		if (value !== DataWidth'(expectedCount))
			reportMismatch("count after wait states", DataWidth'(expectedCount), value);
		waitForCount(expectedCount);
		apbRead(ApbAddrWidth'(ops[i].dest), value);
		if (value !== regModel[ops[i].dest])
			reportMismatch($sformatf("r%0d", ops[i].dest), regModel[ops[i].dest], value);
	end
	finishTest();
endtask

// client 2 pushes every cycle, only the pushes seen with full low count
task automatic backPressureTest();
	opRequestT req;
	int acceptedCount;
	logic sawFull;
	logic [DataWidth-1:0] value;
	startTest("back-pressure");
	acceptedCount = 0;
	sawFull = 1'b0;
	for (int i = 0; i < 8; i++)
	begin
		@(negedge Clock);
		req = makeRequest(opCodeT'(i % 3), 14, randomBits(RegAddrWidth), 14);
		push[2] = 1'b1;   // held high even while full
		request[2] = req;
		if (full[2])
			sawFull = 1'b1;   // this one is dropped
		else
		begin
			applyToModel(req);
			acceptedCount++;
		end
	end
	@(negedge Clock);
	push[2] = 1'b0;
	if (!sawFull)
		reportFailure("full never rose on client 2 during back-to-back pushes");
	expectedCount += acceptedCount;
	waitForCount(expectedCount);
	apbRead(ApbAddrWidth'(14), value);
	if (value !== regModel[14])
		reportMismatch("r14 after accepted pushes", regModel[14], value);
	if (full !== '0)
		reportFailure("full still high after the queues drained");
	finishTest();
endtask

// ==== testbench/opUnitTb.sv ====
`timescale 1ns/1ps

module opUnitTb
	import opUnitPkg::*;
();

	localparam int ClockPeriod = 100;
	localparam int ResetCycles = 8;
	// register test is about 110 cycles and each of the ~16 operations
	// needs under 20 cycles with polling, so 4000 leaves a wide margin
	localparam int TimeoutCycles = 4000;
	localparam logic [31:0] LfsrSeed = 32'd65984;
	localparam logic [31:0] LfsrTaps = 32'h80200003;   // x^32+x^22+x^2+x+1

	logic Clock;
	logic Reset;
	logic [NumClients-1:0] push;
	opRequestT [NumClients-1:0] request;
	logic [NumClients-1:0] full;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	logic [ApbAddrWidth-1:0] PADDR;
	logic [DataWidth-1:0] PWDATA;
	logic [DataWidth-1:0] PRDATA;
	logic PREADY;

	logic [31:0] lfsrState;
	logic [DataWidth-1:0] regModel [RegCount];   // expected register contents
	int expectedCount;                           // operations accepted so far
	int waitCycles;                              // PREADY low samples, all transfers
	int cycleCount;
	int errorCount;
	int testErrors;
	int testsRun;
	int failedTests;
	string currentTest;

	opUnitTop dut
	(
		.Clock(Clock),
		.Reset(Reset),
		.push(push),
		.request(request),
		.full(full),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PRDATA(PRDATA),
		.PREADY(PREADY)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	// run limit
	always @(posedge Clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycleCount);
			$display("sim failed");
			$finish;
		end
	end

	// ----------------------------------------
	// random data
	// ----------------------------------------
	function automatic logic lfsrStep();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ LfsrTaps;   // galois feedback
		return outBit;
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[30:0], lfsrStep()};
		return value;
	endfunction

	// ----------------------------------------
	// apb master
	// ----------------------------------------
	task automatic apbWrite(input logic [ApbAddrWidth-1:0] addr,
		input logic [DataWidth-1:0] data);
		@(negedge Clock);
		PSEL = 1'b1;   // setup
		PENABLE = 1'b0;
		PWRITE = 1'b1;
		PADDR = addr;
		PWDATA = data;
		@(negedge Clock);
		PENABLE = 1'b1;   // access
		@(posedge Clock);
		while (!PREADY)
		begin
			waitCycles++;
			@(posedge Clock);   // wait states
		end
		@(negedge Clock);
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		if (addr < ApbAddrWidth'(RegCount))
			regModel[addr[RegAddrWidth-1:0]] = data;
	endtask

	task automatic apbRead(input logic [ApbAddrWidth-1:0] addr,
		output logic [DataWidth-1:0] data);
		@(negedge Clock);
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = addr;
		@(negedge Clock);
		PENABLE = 1'b1;
		@(posedge Clock);
		while (!PREADY)
		begin
			waitCycles++;
			@(posedge Clock);
		end
		data = PRDATA;   // value before the edge
		@(negedge Clock);
		PSEL = 1'b0;
		PENABLE = 1'b0;
	endtask

	// one push cycle on the selected clients
	task automatic pushClients(input logic [NumClients-1:0] which,
		input opRequestT [NumClients-1:0] reqs, output logic [NumClients-1:0] accepted);
		@(negedge Clock);
		accepted = which & ~full;   // full queues drop the push
		push = which;
		request = reqs;
		@(negedge Clock);
		push = '0;
	endtask

	// ----------------------------------------
	// reference model and reporting
	// ----------------------------------------
	function automatic logic [DataWidth-1:0] computeOp(input opCodeT op,
		input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
		case (op)
			OpAdd: return a + b;
			OpOr: return a | b;
			OpAnd: return a & b;
			default: return '0;
		endcase
	endfunction

	function automatic opRequestT makeRequest(input opCodeT op, input int srcA, input int srcB,
		input int dest);
		opRequestT r;
		r.opCode = op;
		r.srcA = RegAddrWidth'(srcA);
		r.srcB = RegAddrWidth'(srcB);
		r.dest = RegAddrWidth'(dest);
		return r;
	endfunction

	function automatic void applyToModel(input opRequestT r);
		regModel[r.dest] = computeOp(r.opCode, regModel[r.srcA], regModel[r.srcB]);
	endfunction

	task automatic reportMismatch(input string what, input logic [DataWidth-1:0] expected,
		input logic [DataWidth-1:0] actual);
		$display("ERROR %s, %s: expected 0x%h, actual 0x%h", currentTest, what, expected, actual);
		errorCount++;
		testErrors++;
	endtask

	task automatic reportFailure(input string what);
		$display("%s: %s", currentTest, what);
		errorCount++;
		testErrors++;
	endtask

	task automatic startTest(input string name);
		currentTest = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		testsRun++;
		if (testErrors == 0)
			$display("%-16s ok", currentTest);
		else
		begin
			failedTests++;
			$display("%-16s FAILED with %0d errors", currentTest, testErrors);
		end
	endtask

	// polls the counter until it reaches target
	task automatic waitForCount(input int target);
		logic [DataWidth-1:0] count;
		apbRead(ApbAddrWidth'(StatusAddr), count);
		while (count < DataWidth'(target))
			apbRead(ApbAddrWidth'(StatusAddr), count);
		if (count !== DataWidth'(target))
			reportMismatch("completion count", DataWidth'(target), count);
	endtask

	`include "opUnitTests.svh"

	initial
	begin
		Clock = 1'b0;
		Reset = 1'b1;
		push = '0;
		request = '0;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		lfsrState = LfsrSeed;
		expectedCount = 0;
		waitCycles = 0;
		cycleCount = 0;
		errorCount = 0;
		testErrors = 0;
		testsRun = 0;
		failedTests = 0;
		repeat (ResetCycles) @(negedge Clock);
		Reset = 1'b0;

		resetStateTest();
		registerFileTest();
		roundRobinTest();   // arbiter pointer still at client 0 here
		opcodeTest();
		backPressureTest();

		$display("%0d tests, %0d failed, %0d errors", testsRun, failedTests, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+testbench
verilog/opUnitPkg.sv
verilog/regPortIf.sv
verilog/requestFifo.sv
verilog/roundRobinArbiter.sv
verilog/registerFile.sv
verilog/opExecutor.sv
verilog/apbRegAccess.sv
verilog/opUnitTop.sv
testbench/opUnitTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = opUnitTb
FILELIST = src.f
BUILDDIR = obj_dir
BIN      = $(BUILDDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) testbench/opUnitTests.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
